// File: include/sched_config.svh
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// ============================================================
// Pass scheduler widths and constants
// ============================================================

// Ifmap and weight memory address width
`define SCHED_ADDR_W 10

// Pass counter width, covers 1024 passes of layer 3
`define SCHED_PASS_W 10

// Row index within a tile, up to 256 rows
`define SCHED_ROW_W 8

// Batch id width
`define SCHED_BATCH_W 3

// Tile within a batch, up to 4 tiles
`define SCHED_TILE_W 2

// Block RAM settle cycles before transpose start
`define SCHED_BRAM_WAIT 3

// Ifmap memory depth in words
`define SCHED_IFMAP_DEPTH 1024

`endif

// File: project.f
+incdir+include
src/sched_pkg.sv
src/pass_decoder.sv
src/sched_ctrl.sv
src/addr_gen.sv
src/pass_scheduler.sv
sim/tb_pass_scheduler.sv

// File: sim/tb_pass_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module tb_pass_scheduler;

    // About 630 passes of at most 14 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 20000;
    // Idle cycles watched after a batch_done
    localparam int QUIET_CYCLES   = 10;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    sched_pkg::layer_t         layer_id;
    logic [`SCHED_BATCH_W-1:0] batch_id;
    logic                      transpose_done;
    logic                      load_start;
    logic                      transpose_start;
    logic                      batch_done;
    sched_pkg::row_t           row_id;
    sched_pkg::abs_tile_t      tile_id;
    logic [3:0]                ifmap_sel;
    sched_pkg::addr_t          ifmap_addr_start;
    sched_pkg::addr_t          ifmap_addr_end;
    sched_pkg::addr_t          weight_addr_start;
    sched_pkg::addr_t          weight_addr_end;

    // Transpose responder state
    logic        stray_en;
    int          stray_cnt;
    int          reply_cnt;
    logic [15:0] lfsr_state;

    // Run bookkeeping
    string cur_test;
    int    cycle_count;
    int    check_count;
    int    error_count;
    int    errors_at_test_start;
    int    tests_run;
    int    tests_failed;

    pass_scheduler u_dut (.*);

    // ============================================================
    // Clock, watchdog and transpose responder
    // ============================================================

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    // Transpose latency of 0 to 7 cycles
    function automatic int draw_delay();
        int value;
        value = 0;
        repeat (3) begin
            value = (value << 1) | int'(next_random_bit());
        end
        return value;
    endfunction

    // Answers transpose_start, and optionally fires a stray pulse during WAIT_BRAM
    always @(posedge clk) begin
        #1;
        transpose_done = 1'b0;
        if (!rst_n) begin
            stray_cnt = 0;
            reply_cnt = 0;
        end else begin
            if (stray_cnt > 0) begin
                stray_cnt = stray_cnt - 1;
                transpose_done = (stray_cnt == 0);
            end
            if (reply_cnt > 0) begin
                reply_cnt = reply_cnt - 1;
                if (reply_cnt == 0) begin
                    transpose_done = 1'b1;
                end
            end
            if (load_start && stray_en) begin
                stray_cnt = 1;
            end
            // First cycle in WAIT_TRANS is one edge after transpose_start
            if (transpose_start) begin
                reply_cnt = draw_delay() + 1;
            end
        end
    end

    // ============================================================
    // Checking helpers
    // ============================================================

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("Error: test %s, %s: expected %0d, actual %0d",
                     cur_test, what, expected, actual);
        end
    endtask

    // Reference decode of one pass from the layer table and range rules
    task automatic expected_pass(input int pass, input int layer, output int row,
                                 output int tile, output int if_start, output int if_end,
                                 output int w_start, output int w_end);
        int rows;
        int seg_size;
        int w_size;
        rows     = 32 << layer;
        row      = pass % rows;
        tile     = pass / rows;
        // One segment per 16 rows shares the ifmap memory
        seg_size = `SCHED_IFMAP_DEPTH / (rows / 16);
        if_start = (row / 16) * seg_size;
        if_end   = if_start + seg_size - 1;
        w_size   = (layer == 3) ? 64 : 256;
        w_start  = tile * w_size;
        w_end    = w_start + w_size - 1;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_value("load_start after reset", 0, load_start);
        check_value("transpose_start after reset", 0, transpose_start);
        check_value("batch_done after reset", 0, batch_done);
        check_value("row_id after reset", 0, row_id);
        check_value("tile_id after reset", 0, tile_id);
        check_value("ifmap_sel after reset", 0, ifmap_sel);
        check_value("ifmap_addr_start after reset", 0, ifmap_addr_start);
        check_value("ifmap_addr_end after reset", 0, ifmap_addr_end);
        check_value("weight_addr_start after reset", 0, weight_addr_start);
        check_value("weight_addr_end after reset", 0, weight_addr_end);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        start    = 1'b0;
        stray_en = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic start_test(input string name);
        cur_test             = name;
        errors_at_test_start = error_count;
        tests_run            = tests_run + 1;
    endtask

    task automatic finish_test();
        int errs;
        errs = error_count - errors_at_test_start;
        if (errs != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %s done with %0d errors", cur_test, errs);
    endtask

    // ============================================================
    // Batch driver and monitor
    // ============================================================

    // Full runs end on batch_done, partial runs after the transpose_start of the last pass
    task automatic run_batch(input int layer, input int batch, input int passes,
                             input logic full, input logic stray);
        int   launched;
        int   since_load;
        int   e_row;
        int   e_tile;
        int   e_if_start;
        int   e_if_end;
        int   e_w_start;
        int   e_w_end;
        logic prev_done;
        logic finished;
        launched   = 0;
        since_load = 0;
        prev_done  = 1'b0;
        finished   = 1'b0;
        @(posedge clk);
        #1;
        layer_id = sched_pkg::layer_t'(layer);
        batch_id = batch[`SCHED_BATCH_W-1:0];
        stray_en = stray;
        start    = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        while (!finished) begin
            @(negedge clk);
            since_load = since_load + 1;
            if (load_start) begin
                if (launched > 0) begin
                    check_value("transpose_done one cycle before load_start", 1, prev_done);
                end
                check_value("load_start within pass count", 1, int'(launched < passes));
                expected_pass(launched, layer, e_row, e_tile, e_if_start, e_if_end,
                              e_w_start, e_w_end);
                check_value("row_id", e_row, row_id);
                check_value("tile_id", batch * 4 + e_tile, tile_id);
                check_value("ifmap_sel", e_row % 16, ifmap_sel);
                check_value("ifmap_addr_start", e_if_start, ifmap_addr_start);
                check_value("ifmap_addr_end", e_if_end, ifmap_addr_end);
                check_value("weight_addr_start", e_w_start, weight_addr_start);
                check_value("weight_addr_end", e_w_end, weight_addr_end);
                launched   = launched + 1;
                since_load = 0;
            end
            if (transpose_start) begin
                check_value("cycles from load_start to transpose_start",
                            `SCHED_BRAM_WAIT + 1, since_load);
                if (!full && launched == passes) begin
                    finished = 1'b1;
                end
            end
            if (batch_done) begin
                check_value("transpose_done one cycle before batch_done", 1, prev_done);
                check_value("load_start pulses in batch", passes, launched);
                finished = 1'b1;
            end
            prev_done = transpose_done;
        end
        // Scheduler stays silent until the next start
        if (full) begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                check_value("pulses after batch_done", 0,
                            load_start | transpose_start | batch_done);
            end
        end
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic test_reset_state();
        start_test("reset_state");
        check_reset_state();
        finish_test();
    endtask

    task automatic test_layer0_batch();
        start_test("layer0_batch5");
        run_batch(0, 5, 128, 1'b1, 1'b1);
        finish_test();
    endtask

    task automatic test_layer2_batch();
        start_test("layer2_batch3");
        run_batch(2, 3, 128, 1'b1, 1'b0);
        finish_test();
    endtask

    task automatic test_partial_batch(input string name, input int layer, input int batch,
                                      input int passes);
        start_test(name);
        run_batch(layer, batch, passes, 1'b0, 1'b0);
        apply_reset();
        check_reset_state();
        finish_test();
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        start          = 1'b0;
        layer_id       = sched_pkg::LAYER0;
        batch_id       = '0;
        transpose_done = 1'b0;
        stray_en       = 1'b0;
        stray_cnt      = 0;
        reply_cnt      = 0;
        lfsr_state     = 16'd56;
        cycle_count    = 0;
        check_count    = 0;
        error_count    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        test_reset_state();
        test_layer0_batch();
        test_layer2_batch();
        // Tile change at row 64 of layer 1, then at row 256 of layer 3
        test_partial_batch("layer1_first70", 1, 6, 70);
        test_partial_batch("layer3_first300", 3, 7, 300);

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module addr_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      launch,
    input  sched_pkg::layer_t         layer_id,
    input  logic [`SCHED_BATCH_W-1:0] batch_id,
    input  sched_pkg::tile_t          tile,
    input  sched_pkg::row_t           row,
    output sched_pkg::row_t           row_id,
    output sched_pkg::abs_tile_t      tile_id,
    output logic [3:0]                ifmap_sel,
    output sched_pkg::addr_t          ifmap_addr_start,
    output sched_pkg::addr_t          ifmap_addr_end,
    output sched_pkg::addr_t          weight_addr_start,
    output sched_pkg::addr_t          weight_addr_end
);

    // Log2 of the layer 0 segment size, half the ifmap depth
    localparam int unsigned IF_TOP_SHIFT = $clog2(`SCHED_IFMAP_DEPTH) - 1;

    // 16 rows per ifmap segment
    localparam int unsigned SEG_ROWS_LOG = 4;

    // Weight tile of 64 words in layer 3, 256 elsewhere
    localparam logic [3:0] W_LOG_L3    = 4'd6;
    localparam logic [3:0] W_LOG_OTHER = 4'd8;

    // Ifmap range
    logic [3:0]       seg;
    logic [3:0]       if_shift;
    sched_pkg::addr_t if_size;
    sched_pkg::addr_t if_start;
    sched_pkg::addr_t if_end;

    // Weight range
    logic [3:0]       w_shift;
    sched_pkg::addr_t w_size;
    sched_pkg::addr_t w_start;
    sched_pkg::addr_t w_end;

    // ============================================================
    // Ifmap segment range
    // ============================================================

    always_comb begin
        seg      = 4'(row >> SEG_ROWS_LOG);
        // Segment count doubles per layer so size halves
        // 512, 256, 128 and 64 words
        if_shift = 4'(IF_TOP_SHIFT) - 4'(layer_id);
        if_size  = sched_pkg::addr_t'(1 << if_shift);
        if_start = sched_pkg::addr_t'(seg) << if_shift;
        if_end   = if_start + if_size - 1'b1;
    end

    // ============================================================
    // Weight tile range
    // ============================================================

    always_comb begin
        w_shift = (layer_id == sched_pkg::LAYER3) ? W_LOG_L3 : W_LOG_OTHER;
        w_size  = sched_pkg::addr_t'(1 << w_shift);
        w_start = sched_pkg::addr_t'(tile) << w_shift;
        w_end   = w_start + w_size - 1'b1;
    end

    // ============================================================
    // Pass descriptor registers
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_id            <= '0;
            tile_id           <= '0;
            ifmap_sel         <= '0;
            ifmap_addr_start  <= '0;
            ifmap_addr_end    <= '0;
            weight_addr_start <= '0;
            weight_addr_end   <= '0;
        end else if (launch) begin
            row_id            <= row;
            // Absolute tile with batch id on top
            tile_id           <= {batch_id, tile};
            // Ifmap bank select from the row low nibble
            ifmap_sel         <= row[3:0];
            ifmap_addr_start  <= if_start;
            ifmap_addr_end    <= if_end;
            weight_addr_start <= w_start;
            weight_addr_end   <= w_end;
        end
    end

endmodule

`default_nettype wire

// File: src/pass_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module pass_decoder (
    input  sched_pkg::pass_t  launch_pass,
    input  sched_pkg::layer_t layer_id,
    output sched_pkg::tile_t  tile,
    output sched_pkg::row_t   row,
    output logic              last_pass
);

    // ============================================================
    // Layer table
    // ============================================================

    // Row index width per layer
    // 32, 64, 128 and 256 rows per tile
    localparam int unsigned ROW_BITS [4] = '{5, 6, 7, 8};

    // Tiles per batch per layer
    localparam int unsigned TILE_CNT [4] = '{4, 4, 1, 4};

    // Pass index of the final pass in a batch
    // Passes per batch are tiles times rows per tile
    localparam int unsigned LAST_IDX [4] = '{
        (TILE_CNT[0] << ROW_BITS[0]) - 1,
        (TILE_CNT[1] << ROW_BITS[1]) - 1,
        (TILE_CNT[2] << ROW_BITS[2]) - 1,
        (TILE_CNT[3] << ROW_BITS[3]) - 1
    };

    // Table lookup results
    logic [3:0]       row_bits;
    sched_pkg::pass_t last_idx;

    // Split of the pass index
    sched_pkg::pass_t row_mask;
    sched_pkg::pass_t row_part;
    sched_pkg::pass_t tile_part;

    // ============================================================
    // Table lookup for the active layer
    // ============================================================

    always_comb begin
        row_bits = 4'(ROW_BITS[layer_id]);
        last_idx = sched_pkg::pass_t'(LAST_IDX[layer_id]);
    end

    // ============================================================
    // Pass index decode
    // ============================================================

    always_comb begin
        // Ones in the row field of this layer
        row_mask  = sched_pkg::pass_t'((1 << row_bits) - 1);

        // Low bits select the row
        row_part  = launch_pass & row_mask;

        // Bits just above the row field select the tile
        tile_part = launch_pass >> row_bits;
    end

    // Row fits in 8 bits for every layer
    assign row  = sched_pkg::row_t'(row_part);

    // Tile stays below 4 for any legal pass index
    assign tile = sched_pkg::tile_t'(tile_part);

    // Flag on the final pass of the batch
    assign last_pass = (launch_pass == last_idx);

endmodule

`default_nettype wire

// File: src/pass_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module pass_scheduler (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  sched_pkg::layer_t         layer_id,
    input  logic [`SCHED_BATCH_W-1:0] batch_id,
    input  logic                      transpose_done,
    output logic                      load_start,
    output logic                      transpose_start,
    output logic                      batch_done,
    output sched_pkg::row_t           row_id,
    output sched_pkg::abs_tile_t      tile_id,
    output logic [3:0]                ifmap_sel,
    output sched_pkg::addr_t          ifmap_addr_start,
    output sched_pkg::addr_t          ifmap_addr_end,
    output sched_pkg::addr_t          weight_addr_start,
    output sched_pkg::addr_t          weight_addr_end
);

    // Pass about to be launched and its decode
    sched_pkg::pass_t launch_pass;
    logic             launch;
    sched_pkg::tile_t tile;
    sched_pkg::row_t  row;
    logic             last_pass;

    // Batch FSM
    sched_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .transpose_done  (transpose_done),
        .last_pass       (last_pass),
        .launch_pass     (launch_pass),
        .launch          (launch),
        .load_start      (load_start),
        .transpose_start (transpose_start),
        .batch_done      (batch_done)
    );

    // Layer-aware pass split
    pass_decoder u_decoder (
        .launch_pass (launch_pass),
        .layer_id    (layer_id),
        .tile        (tile),
        .row         (row),
        .last_pass   (last_pass)
    );

    // Descriptor and address ranges
    addr_gen u_addr (
        .clk               (clk),
        .rst_n             (rst_n),
        .launch            (launch),
        .layer_id          (layer_id),
        .batch_id          (batch_id),
        .tile              (tile),
        .row               (row),
        .row_id            (row_id),
        .tile_id           (tile_id),
        .ifmap_sel         (ifmap_sel),
        .ifmap_addr_start  (ifmap_addr_start),
        .ifmap_addr_end    (ifmap_addr_end),
        .weight_addr_start (weight_addr_start),
        .weight_addr_end   (weight_addr_end)
    );

endmodule

`default_nettype wire

// File: src/sched_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module sched_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             transpose_done,
    input  logic             last_pass,
    output sched_pkg::pass_t launch_pass,
    output logic             launch,
    output logic             load_start,
    output logic             transpose_start,
    output logic             batch_done
);

    // Final count of the block RAM wait
    localparam logic [1:0] BRAM_LAST = 2'(`SCHED_BRAM_WAIT - 1);

    sched_pkg::state_t state;
    sched_pkg::state_t next_state;

    // Cycles spent in WAIT_BRAM
    logic [1:0]        bram_cnt;

    // Index of the pass in flight
    sched_pkg::pass_t  pass_cnt;

    // Pass in flight is the final one of the batch
    logic              cur_last;

    // ============================================================
    // Next state
    // ============================================================

    always_comb begin
        next_state = state;
        case (state)
            sched_pkg::IDLE: begin
                if (start) begin
                    next_state = sched_pkg::LOAD;
                end
            end
            sched_pkg::LOAD: begin
                next_state = sched_pkg::WAIT_BRAM;
            end
            sched_pkg::WAIT_BRAM: begin
                if (bram_cnt == BRAM_LAST) begin
                    next_state = sched_pkg::TRANS;
                end
            end
            sched_pkg::TRANS: begin
                next_state = sched_pkg::WAIT_TRANS;
            end
            sched_pkg::WAIT_TRANS: begin
                // Only back-pressure point of the batch
                if (transpose_done) begin
                    next_state = cur_last ? sched_pkg::FINISH : sched_pkg::LOAD;
                end
            end
            sched_pkg::FINISH: begin
                next_state = sched_pkg::IDLE;
            end
            default: begin
                next_state = sched_pkg::IDLE;
            end
        endcase
    end

    // First pass is zero, later passes follow the counter
    assign launch_pass = (state == sched_pkg::IDLE) ? '0 : pass_cnt + 1'b1;

    // Decision to launch a pass on this edge
    assign launch = (next_state == sched_pkg::LOAD);

    // ============================================================
    // State, counters and pulses
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= sched_pkg::IDLE;
            bram_cnt        <= '0;
            pass_cnt        <= '0;
            cur_last        <= 1'b0;
            load_start      <= 1'b0;
            transpose_start <= 1'b0;
            batch_done      <= 1'b0;
        end else begin
            state <= next_state;

            // Wait counter runs only in WAIT_BRAM
            if (state == sched_pkg::WAIT_BRAM) begin
                bram_cnt <= bram_cnt + 1'b1;
            end else begin
                bram_cnt <= '0;
            end

            // Pass counter
            if (state == sched_pkg::IDLE) begin
                pass_cnt <= '0;
            end else if (state == sched_pkg::WAIT_TRANS && transpose_done) begin
                pass_cnt <= pass_cnt + 1'b1;
            end

            // Remember the last flag of the launched pass
            if (launch) begin
                cur_last <= last_pass;
            end

            // One-cycle pulses on state entry
            load_start      <= launch;
            transpose_start <= (next_state == sched_pkg::TRANS);
            batch_done      <= (next_state == sched_pkg::FINISH);
        end
    end

endmodule

`default_nettype wire

// File: src/sched_pkg.sv
`default_nettype none

`include "sched_config.svh"

package sched_pkg;

    // Active layer of the network
    typedef enum logic [1:0] {
        LAYER0,
        LAYER1,
        LAYER2,
        LAYER3
    } layer_t;

    // Batch FSM states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        WAIT_BRAM,
        TRANS,
        WAIT_TRANS,
        FINISH
    } state_t;

    // Pass descriptor fields
    typedef logic [`SCHED_PASS_W-1:0]                 pass_t;
    typedef logic [`SCHED_ROW_W-1:0]                  row_t;
    typedef logic [`SCHED_TILE_W-1:0]                 tile_t;
    // Batch id in the upper bits
    typedef logic [`SCHED_BATCH_W+`SCHED_TILE_W-1:0]  abs_tile_t;
    typedef logic [`SCHED_ADDR_W-1:0]                 addr_t;

endpackage

`default_nettype wire
